// File: vlog.f
design/fetch_pkg.sv
design/rvc_expander.sv
design/fetch_pc_gen.sv
design/fetch_stage_reg.sv
design/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_properties.sv
verification/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - design/fetch_pkg.sv
  - design/rvc_expander.sv
  - design/fetch_pc_gen.sv
  - design/fetch_stage_reg.sv
  - design/fetch_top.sv
  - target: test
    files:
      - verification/fetch_checker.sv
      - verification/fetch_properties.sv
      - verification/tb_fetch.sv

// File: verification/tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch import fetch_pkg::*; ();

    localparam int PC_WIDTH   = 18;
    localparam int NUM_CYCLES = 2000;
    localparam int MEM_HW     = 4096; // Halfwords, addresses wrap

    logic                clk = 1'b0;
    logic                rst;
    logic                stall;
    logic                flush;
    logic                redirect_valid;
    logic [PC_WIDTH-1:0] redirect_pc;
    instr_t              imem_data;
    logic [PC_WIDTH-1:0] imem_addr;
    instr_t              dec_instr;
    logic [PC_WIDTH-1:0] dec_pc;
    logic [PC_WIDTH-1:0] dec_pc_next;
    logic                done;
    int                  total_checks;
    int                  total_errors;

    rvc_t       mem [MEM_HW];
    logic [11:0] idx_lo;
    logic [11:0] idx_hi;

    // Combinational memory, lower halfword at the address itself
    assign idx_lo    = imem_addr[11:0];
    assign idx_hi    = idx_lo + 12'd1;
    assign imem_data = {mem[idx_hi], mem[idx_lo]};

    fetch_top #(
        .PC_WIDTH (PC_WIDTH)
    ) u_dut (
        .clk_i            (clk),
        .rst_i            (rst),
        .stall_i          (stall),
        .flush_i          (flush),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .imem_data_i      (imem_data),
        .imem_addr_o      (imem_addr),
        .dec_instr_o      (dec_instr),
        .dec_pc_o         (dec_pc),
        .dec_pc_next_o    (dec_pc_next)
    );

    fetch_checker #(
        .PC_WIDTH (PC_WIDTH)
    ) u_checker (
        .clk_i            (clk),
        .rst_i            (rst),
        .stall_i          (stall),
        .flush_i          (flush),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .imem_data_i      (imem_data),
        .imem_addr_i      (imem_addr),
        .dec_instr_i      (dec_instr),
        .dec_pc_i         (dec_pc),
        .dec_pc_next_i    (dec_pc_next),
        .done_i           (done),
        .checks_o         (total_checks),
        .errors_o         (total_errors)
    );

    // One legal compressed parcel from the supported quadrant and funct3 set
    function automatic rvc_t legal_parcel();
        rvc_t p;
        int   form;
        p    = rvc_t'($urandom());
        form = $urandom() % 15;
        if (form < 3) begin
            p[1:0]   = 2'b00;
            p[15:13] = (form == 0) ? 3'b000 : (form == 1) ? 3'b010 : 3'b110;
        end else if (form < 11) begin
            p[1:0]   = 2'b01;
            p[15:13] = 3'(form - 3);
            if (p[15:13] == 3'b100 && p[11:10] != 2'b10) begin
                p[12] = 1'b0;
            end
        end else begin
            p[1:0]   = 2'b10;
            p[15:13] = {3'(form - 11)} << 1;
            if (p[15:13] == 3'b000) begin
                p[12] = 1'b0; // RV32 shift amount
            end
        end
        return p;
    endfunction

    // Reserved or unsupported compressed patterns
    function automatic rvc_t illegal_parcel();
        rvc_t p;
        p = rvc_t'($urandom());
        case ($urandom() % 3)
            0:       p = 16'h0000;
            1:       p = {3'b001, p[12:2], 2'b00}; // c.fld
            default: p = {3'b011, p[12:2], 2'b10}; // c.flwsp
        endcase
        return p;
    endfunction

    task automatic fill_memory();
        int   i;
        int   pick;
        rvc_t lo;
        i = 0;
        while (i < MEM_HW) begin
            pick = $urandom() % 100;
            if (pick < 42) begin
                mem[i] = legal_parcel();
                i++;
            end else if (pick < 52) begin
                mem[i] = illegal_parcel();
                i++;
            end else begin
                lo                    = rvc_t'($urandom());
                mem[i]                = {lo[15:2], 2'b11};
                mem[(i + 1) % MEM_HW] = rvc_t'($urandom());
                i += 2;
            end
        end
    endtask

    initial begin
        forever #50 clk = ~clk;
    end

    // Watchdog sized from the test length
    initial begin
        #((NUM_CYCLES + 16 + 100) * 100);
        $display("Error: the run did not finish in time, simulation stopped by the watchdog");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        stall          = 1'b0;
        flush          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        done           = 1'b0;
        void'($urandom(32'h2cabc796));
        fill_memory();
        repeat (16) @(posedge clk);
        #10 rst = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            #10;
            stall          = ($urandom() % 100) < 20;
            flush          = ($urandom() % 100) < 10;
            redirect_valid = ($urandom() % 100) < 10;
            redirect_pc    = PC_WIDTH'($urandom());
        end
        @(posedge clk);
        #10;
        stall          = 1'b0;
        flush          = 1'b0;
        redirect_valid = 1'b0;
        repeat (2) @(posedge clk);
        done = 1'b1;
        #1;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errors, u_dut.u_properties.fail_count);
        if (total_errors == 0 && total_checks > 0 && u_dut.u_properties.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/fetch_properties.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_properties import fetch_pkg::*; #(
    parameter int PC_WIDTH = 18
) (
    input logic                clk_i,
    input logic                rst_i,
    input logic                stall_i,
    input logic                flush_i,
    input logic                redirect_valid_i,
    input logic [PC_WIDTH-1:0] redirect_pc_i,
    input logic [PC_WIDTH-1:0] imem_addr_o,
    input instr_t              dec_instr_o
);

    int fail_count = 0; // Failed assertion count

    // Fetch address frozen by a stall
    assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> imem_addr_o == $past(imem_addr_o))
        else begin
            fail_count++;
            $error("imem_addr_o changed across a stalled cycle");
        end

    assert property (@(posedge clk_i) disable iff (rst_i)
        (!stall_i && flush_i) |=> dec_instr_o == EBREAK_INSTR)
        else begin
            fail_count++;
            $error("dec_instr_o is not the bubble after a flush");
        end

    assert property (@(posedge clk_i) disable iff (rst_i)
        (!stall_i && redirect_valid_i) |=> imem_addr_o == $past(redirect_pc_i))
        else begin
            fail_count++;
            $error("imem_addr_o missed the redirect target");
        end

endmodule

bind fetch_top fetch_properties #(
    .PC_WIDTH (PC_WIDTH)
) u_properties (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .stall_i          (stall_i),
    .flush_i          (flush_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .imem_addr_o      (imem_addr_o),
    .dec_instr_o      (dec_instr_o)
);

`default_nettype wire

// File: verification/fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_checker import fetch_pkg::*; #(
    parameter int PC_WIDTH = 18
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  logic                redirect_valid_i,
    input  logic [PC_WIDTH-1:0] redirect_pc_i,
    input  instr_t              imem_data_i,
    input  logic [PC_WIDTH-1:0] imem_addr_i,
    input  instr_t              dec_instr_i,
    input  logic [PC_WIDTH-1:0] dec_pc_i,
    input  logic [PC_WIDTH-1:0] dec_pc_next_i,
    input  logic                done_i,
    output int                  checks_o,
    output int                  errors_o
);

    localparam int T_RESET = 0;
    localparam int T_SEQ   = 1;
    localparam int T_EXP   = 2;
    localparam int T_STALL = 3;
    localparam int T_FLUSH = 4;
    localparam int T_REDIR = 5;

    int    checks [6];
    int    errors [6];
    string names  [6];
    logic  have_prev;
    logic  reset_reported;

    // Snapshot of the previous cycle
    logic                p_stall;
    logic                p_flush;
    logic                p_redir;
    logic [PC_WIDTH-1:0] p_target;
    logic [PC_WIDTH-1:0] p_addr;
    instr_t              p_data;
    instr_t              p_dec_instr;
    logic [PC_WIDTH-1:0] p_dec_pc;
    logic [PC_WIDTH-1:0] p_dec_pc_next;
    logic [PC_WIDTH-1:0] exp_seq;
    logic [PC_WIDTH-1:0] model_pc; // Expected fetch address

    initial begin
        names          = '{"reset", "sequential", "expansion", "stall", "flush", "redirect"};
        checks         = '{default: 0};
        errors         = '{default: 0};
        have_prev      = 1'b0;
        reset_reported = 1'b0;
        checks_o       = 0;
        errors_o       = 0;
    end

    // Base format encoders
    function automatic instr_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_b(logic [12:0] imm, logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic instr_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // Reference expansion, built from offsets first and then encoded
    function automatic instr_t model_expand(instr_t w);
        rvc_t        c;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rs1p;
        logic [4:0]  rs2p;
        logic [11:0] imm6s;
        logic [9:0]  u10;
        logic [6:0]  u7;
        logic [7:0]  u8;
        logic [11:0] joff;
        logic [8:0]  boff;
        instr_t      r;
        c     = w[15:0];
        rd    = c[11:7];
        rs2   = c[6:2];
        rs1p  = 5'd8 + {2'b00, c[9:7]};
        rs2p  = 5'd8 + {2'b00, c[4:2]};
        imm6s = {{6{c[12]}}, c[12], c[6:2]};
        u7    = {c[5], c[12:10], c[6], 2'b00};
        joff  = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        boff  = {c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        r     = '0;
        if (c[1:0] == 2'b11) begin
            return w;
        end
        case ({c[1:0], c[15:13]})
            5'b00_000: begin
                u10 = {c[10:7], c[12:11], c[5], c[6], 2'b00};
                if (u10 != 10'd0) r = enc_i({2'b00, u10}, 5'd2, 3'b000, rs2p, OPC_OP_IMM);
            end
            5'b00_010: r = enc_i({5'b0, u7}, rs1p, 3'b010, rs2p, OPC_LOAD);
            5'b00_110: r = enc_s({5'b0, u7}, rs2p, rs1p);
            5'b01_000: r = enc_i(imm6s, rd, 3'b000, rd, OPC_OP_IMM);
            5'b01_001: r = enc_j({{9{joff[11]}}, joff}, 5'd1);
            5'b01_101: r = enc_j({{9{joff[11]}}, joff}, 5'd0);
            5'b01_010: r = enc_i(imm6s, 5'd0, 3'b000, rd, OPC_OP_IMM);
            5'b01_011: begin
                if (rd == 5'd2) begin
                    u10 = {c[12], c[4:3], c[5], c[2], c[6], 4'b0};
                    if (u10 != 10'd0) begin
                        r = enc_i({{2{u10[9]}}, u10}, 5'd2, 3'b000, 5'd2, OPC_OP_IMM);
                    end
                end else if ({c[12], c[6:2]} != 6'd0) begin
                    r = {{14{c[12]}}, c[12], c[6:2], rd, OPC_LUI};
                end
            end
            5'b01_100: begin
                case (c[11:10])
                    2'b00:   if (!c[12]) r = enc_i({7'b0, c[6:2]}, rs1p, 3'b101, rs1p, OPC_OP_IMM);
                    2'b01:   if (!c[12]) r = enc_i({7'b0100000, c[6:2]}, rs1p, 3'b101, rs1p,
                                                   OPC_OP_IMM);
                    2'b10:   r = enc_i(imm6s, rs1p, 3'b111, rs1p, OPC_OP_IMM);
                    default: begin
                        if (!c[12]) begin
                            case (c[6:5])
                                2'b00:   r = enc_r(7'b0100000, rs2p, rs1p, 3'b000, rs1p);
                                2'b01:   r = enc_r(7'b0, rs2p, rs1p, 3'b100, rs1p);
                                2'b10:   r = enc_r(7'b0, rs2p, rs1p, 3'b110, rs1p);
                                default: r = enc_r(7'b0, rs2p, rs1p, 3'b111, rs1p);
                            endcase
                        end
                    end
                endcase
            end
            5'b01_110, 5'b01_111: r = enc_b({{4{c[12]}}, boff}, rs1p, {2'b00, c[13]});
            5'b10_000: if (!c[12]) r = enc_i({7'b0, c[6:2]}, rd, 3'b001, rd, OPC_OP_IMM);
            5'b10_010: begin
                u8 = {c[3:2], c[12], c[6:4], 2'b00};
                if (rd != 5'd0) r = enc_i({4'b0, u8}, 5'd2, 3'b010, rd, OPC_LOAD);
            end
            5'b10_100: begin
                if (!c[12]) begin
                    if (rs2 != 5'd0) r = enc_r(7'b0, rs2, 5'd0, 3'b000, rd); // mv
                    else if (rd != 5'd0) r = enc_i(12'd0, rd, 3'b000, 5'd0, OPC_JALR);
                end else if (rs2 != 5'd0) begin
                    r = enc_r(7'b0, rs2, rd, 3'b000, rd); // add
                end else if (rd == 5'd0) begin
                    r = 32'h0010_0073; // ebreak encoding
                end else begin
                    r = enc_i(12'd0, rd, 3'b000, 5'd1, OPC_JALR);
                end
            end
            5'b10_110: begin
                u8 = {c[8:7], c[12:9], 2'b00};
                r  = enc_s({4'b0, u8}, rs2, 5'd2);
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic compare_value(int t, string sig, logic [31:0] exp, logic [31:0] got);
        checks[t]++;
        if (exp !== got) begin
            errors[t]++;
            $display("FAIL %s expected %h got %h (%s, %0t ns)", sig, exp, got, names[t], $time);
        end
    endtask

    // Sampled at the falling edge, well clear of the input updates
    always @(negedge clk_i) begin
        if (rst_i) begin
            have_prev = 1'b0;
            model_pc  = '0;
            compare_value(T_RESET, "imem_addr_o", 32'd0, 32'(imem_addr_i));
            compare_value(T_RESET, "dec_instr_o", EBREAK_INSTR, dec_instr_i);
            compare_value(T_RESET, "dec_pc_o", 32'd0, 32'(dec_pc_i));
            compare_value(T_RESET, "dec_pc_next_o", 32'd0, 32'(dec_pc_next_i));
        end else begin
            if (!reset_reported) begin
                reset_reported = 1'b1;
                $display("test %-10s done: %0d checks, %0d errors",
                         names[T_RESET], checks[T_RESET], errors[T_RESET]);
            end
            if (have_prev && p_stall) begin
                compare_value(T_STALL, "imem_addr_o", 32'(p_addr), 32'(imem_addr_i));
                compare_value(T_STALL, "dec_instr_o", p_dec_instr, dec_instr_i);
                compare_value(T_STALL, "dec_pc_o", 32'(p_dec_pc), 32'(dec_pc_i));
                compare_value(T_STALL, "dec_pc_next_o", 32'(p_dec_pc_next), 32'(dec_pc_next_i));
            end else if (have_prev) begin
                exp_seq  = p_addr + ((p_data[1:0] != 2'b11) ? 1 : 2);
                model_pc = p_redir ? p_target : exp_seq;
                if (p_redir) begin
                    compare_value(T_REDIR, "imem_addr_o", 32'(model_pc), 32'(imem_addr_i));
                end else begin
                    compare_value(T_SEQ, "imem_addr_o", 32'(model_pc), 32'(imem_addr_i));
                end
                compare_value(T_SEQ, "dec_pc_o", 32'(p_addr), 32'(dec_pc_i));
                compare_value(T_SEQ, "dec_pc_next_o", 32'(exp_seq), 32'(dec_pc_next_i));
                if (p_flush) begin
                    compare_value(T_FLUSH, "dec_instr_o", EBREAK_INSTR, dec_instr_i);
                end else begin
                    compare_value(T_EXP, "dec_instr_o", model_expand(p_data), dec_instr_i);
                end
            end
            p_stall       = stall_i;
            p_flush       = flush_i;
            p_redir       = redirect_valid_i;
            p_target      = redirect_pc_i;
            p_addr        = model_pc;
            p_data        = imem_data_i;
            p_dec_instr   = dec_instr_i;
            p_dec_pc      = dec_pc_i;
            p_dec_pc_next = dec_pc_next_i;
            have_prev     = 1'b1;
        end
    end

    always @(posedge done_i) begin
        for (int t = T_SEQ; t <= T_REDIR; t++) begin
            $display("test %-10s done: %0d checks, %0d errors", names[t], checks[t], errors[t]);
        end
        checks_o = 0;
        errors_o = 0;
        for (int t = 0; t < 6; t++) begin
            checks_o += checks[t];
            errors_o += errors[t];
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter int PC_WIDTH = 18
) (
    input  logic                clk_i,
    input  logic                rst_i,

    // Pipeline control
    input  logic                stall_i,
    input  logic                flush_i,
    input  logic                redirect_valid_i,
    input  logic [PC_WIDTH-1:0] redirect_pc_i,

    // Instruction memory, read in the same cycle
    input  instr_t              imem_data_i,
    output logic [PC_WIDTH-1:0] imem_addr_o,

    // To decode
    output instr_t              dec_instr_o,
    output logic [PC_WIDTH-1:0] dec_pc_o,
    output logic [PC_WIDTH-1:0] dec_pc_next_o
);

    logic [PC_WIDTH-1:0] pc;
    logic [PC_WIDTH-1:0] pc_next_seq;
    logic                is_compressed;
    instr_t              instr_full;

    fetch_pc_gen #(
        .PC_WIDTH (PC_WIDTH)
    ) u_pc_gen (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .is_compressed_i  (is_compressed),
        .pc_o             (pc),
        .pc_next_seq_o    (pc_next_seq)
    );

    assign imem_addr_o = pc;

    rvc_expander u_rvc_expander (
        .instr_raw_i     (imem_data_i),
        .is_compressed_o (is_compressed),
        .instr_o         (instr_full)
    );

    fetch_stage_reg #(
        .PC_WIDTH (PC_WIDTH)
    ) u_stage_reg (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .instr_i       (instr_full),
        .pc_i          (pc),
        .pc_next_seq_i (pc_next_seq),
        .dec_instr_o   (dec_instr_o),
        .dec_pc_o      (dec_pc_o),
        .dec_pc_next_o (dec_pc_next_o)
    );

endmodule

`default_nettype wire

// File: design/fetch_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage_reg import fetch_pkg::*; #(
    parameter int PC_WIDTH = 18
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  instr_t              instr_i,
    input  logic [PC_WIDTH-1:0] pc_i,
    input  logic [PC_WIDTH-1:0] pc_next_seq_i,
    output instr_t              dec_instr_o,
    output logic [PC_WIDTH-1:0] dec_pc_o,
    output logic [PC_WIDTH-1:0] dec_pc_next_o
);

    instr_t              instr_q;
    logic [PC_WIDTH-1:0] pc_q;
    logic [PC_WIDTH-1:0] pc_next_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_q   <= EBREAK_INSTR; // Decode starts on a bubble
            pc_q      <= '0;
            pc_next_q <= '0;
        end else if (!stall_i) begin
            instr_q   <= flush_i ? EBREAK_INSTR : instr_i;
            pc_q      <= pc_i;
            pc_next_q <= pc_next_seq_i; // Sequential address, even after a redirect
        end
    end

    assign dec_instr_o   = instr_q;
    assign dec_pc_o      = pc_q;
    assign dec_pc_next_o = pc_next_q;

endmodule

`default_nettype wire

// File: design/fetch_pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen #(
    parameter int PC_WIDTH = 18 // Halfword address width
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  logic                redirect_valid_i,
    input  logic [PC_WIDTH-1:0] redirect_pc_i,
    input  logic                is_compressed_i,
    output logic [PC_WIDTH-1:0] pc_o,
    output logic [PC_WIDTH-1:0] pc_next_seq_o
);

    logic [PC_WIDTH-1:0] pc_q;
    logic [PC_WIDTH-1:0] pc_d;
    logic [1:0]          step;

    // One halfword for a compressed parcel, two for a full word
    assign step = is_compressed_i ? 2'd1 : 2'd2;

    assign pc_next_seq_o = pc_q + {{(PC_WIDTH-2){1'b0}}, step};

    // Redirect overrides the fall-through
    assign pc_d = redirect_valid_i ? redirect_pc_i : pc_next_seq_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (!stall_i) begin
            pc_q <= pc_d; // Also drops the redirect strobe when stalled
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: design/rvc_expander.sv
`timescale 1ns/1ns
`default_nettype none

module rvc_expander import fetch_pkg::*; (
    input  instr_t instr_raw_i,
    output logic   is_compressed_o,
    output instr_t instr_o
);

    rvc_t       c;
    logic [4:0] rd;        // Full register fields
    logic [4:0] rs2;
    logic [4:0] rp_hi;     // Primed fields, x8 to x15
    logic [4:0] rp_lo;
    instr_t     expanded;

    assign c     = instr_raw_i[15:0];
    assign rd    = c[11:7];
    assign rs2   = c[6:2];
    assign rp_hi = {2'b01, c[9:7]};
    assign rp_lo = {2'b01, c[4:2]};

    // Quadrant 3 is the only 32-bit encoding
    assign is_compressed_o = (c[1:0] != 2'b11);
    assign instr_o         = is_compressed_o ? expanded : instr_raw_i;

    always_comb begin
        expanded = '0; // Anything not matched below stays illegal
        case (c[1:0])
            // Quadrant 0
            2'b00: begin
                case (c[15:13])
                    3'b000: begin // c.addi4spn, zero immediate is reserved
                        if (c[12:5] != 8'b0) begin
                            expanded = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                        RVC_SP_REG, 3'b000, rp_lo, OPC_OP_IMM};
                        end
                    end
                    3'b010: begin // c.lw
                        expanded = {5'b0, c[5], c[12:10], c[6], 2'b00,
                                    rp_hi, 3'b010, rp_lo, OPC_LOAD};
                    end
                    3'b110: begin // c.sw
                        expanded = {5'b0, c[5], c[12], rp_lo, rp_hi, 3'b010,
                                    c[11:10], c[6], 2'b00, OPC_STORE};
                    end
                    default: ;
                endcase
            end
            // Quadrant 1
            2'b01: begin
                case (c[15:13])
                    3'b000: begin // c.addi and c.nop
                        expanded = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, OPC_OP_IMM};
                    end
                    3'b001, 3'b101: begin // c.jal links x1, c.j links x0
                        expanded = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                    c[12], {8{c[12]}}, 4'b0, ~c[15], OPC_JAL};
                    end
                    3'b010: begin // c.li
                        expanded = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, OPC_OP_IMM};
                    end
                    3'b011: begin
                        if (rd == RVC_SP_REG) begin
                            if ({c[12], c[6:2]} != 6'b0) begin // c.addi16sp
                                expanded = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0,
                                            RVC_SP_REG, 3'b000, RVC_SP_REG, OPC_OP_IMM};
                            end
                        end else if ({c[12], c[6:2]} != 6'b0) begin // c.lui
                            expanded = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
                        end
                    end
                    3'b100: begin
                        case (c[11:10])
                            2'b00, 2'b01: begin // c.srli, c.srai
                                if (!c[12]) begin // shamt[5] must be 0 on RV32
                                    expanded = {1'b0, c[10], 5'b0, c[6:2],
                                                rp_hi, 3'b101, rp_hi, OPC_OP_IMM};
                                end
                            end
                            2'b10: begin // c.andi
                                expanded = {{7{c[12]}}, c[6:2], rp_hi, 3'b111, rp_hi, OPC_OP_IMM};
                            end
                            default: begin
                                if (!c[12]) begin // Bit 12 set is RV64 only
                                    case (c[6:5])
                                        2'b00: expanded = {7'b0100000, rp_lo, rp_hi,
                                                           3'b000, rp_hi, OPC_OP}; // c.sub
                                        2'b01: expanded = {7'b0, rp_lo, rp_hi,
                                                           3'b100, rp_hi, OPC_OP}; // c.xor
                                        2'b10: expanded = {7'b0, rp_lo, rp_hi,
                                                           3'b110, rp_hi, OPC_OP}; // c.or
                                        default: expanded = {7'b0, rp_lo, rp_hi,
                                                             3'b111, rp_hi, OPC_OP}; // c.and
                                    endcase
                                end
                            end
                        endcase
                    end
                    default: begin // c.beqz and c.bnez, bit 13 picks the funct3
                        expanded = {c[12], {3{c[12]}}, c[6:5], c[2], 5'd0, rp_hi,
                                    2'b00, c[13], c[11:10], c[4:3], c[12], OPC_BRANCH};
                    end
                endcase
            end
            // Quadrant 2
            2'b10: begin
                case (c[15:13])
                    3'b000: begin // c.slli
                        if (!c[12]) begin
                            expanded = {7'b0, c[6:2], rd, 3'b001, rd, OPC_OP_IMM};
                        end
                    end
                    3'b010: begin // c.lwsp, rd of x0 is reserved
                        if (rd != 5'd0) begin
                            expanded = {4'b0, c[3:2], c[12], c[6:4], 2'b00,
                                        RVC_SP_REG, 3'b010, rd, OPC_LOAD};
                        end
                    end
                    3'b100: begin
                        if (!c[12]) begin
                            if (rs2 == 5'd0) begin
                                if (rd != 5'd0) begin // c.jr
                                    expanded = {12'b0, rd, 3'b000, 5'd0, OPC_JALR};
                                end
                            end else begin // c.mv
                                expanded = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};
                            end
                        end else if (rs2 == 5'd0) begin
                            if (rd == 5'd0) begin
                                expanded = EBREAK_INSTR; // c.ebreak
                            end else begin // c.jalr
                                expanded = {12'b0, rd, 3'b000, 5'd1, OPC_JALR};
                            end
                        end else begin // c.add
                            expanded = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
                        end
                    end
                    3'b110: begin // c.swsp
                        expanded = {4'b0, c[8:7], c[12], rs2, RVC_SP_REG, 3'b010,
                                    c[11:9], 2'b00, OPC_STORE};
                    end
                    default: ;
                endcase
            end
            default: ; // 32-bit word, bypassed at the output mux
        endcase
    end

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Full 32-bit instruction word
    typedef logic [31:0] instr_t;

    // One 16-bit compressed parcel
    typedef logic [15:0] rvc_t;

    // Base opcodes, bits [6:0] of an expanded word
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Stack pointer, implicit base of the SP-relative forms
    localparam logic [4:0] RVC_SP_REG = 5'd2;

    // Bubble word for reset and flush
    // An all-zero word would decode as the illegal instruction, so EBREAK is used
    localparam instr_t EBREAK_INSTR = 32'h0010_0073;

endpackage

`default_nettype wire
